//--- bench/aluSystemTb.sv
`timescale 1ns/100ps
`default_nettype none

module aluSystemTb;

    localparam int resetCycles = 16;
    localparam int marginCycles = 20;
    localparam int fieldCount = 19;                     // Columns per vector line
    localparam string testFile = "bench/aluSystemTests.txt";

    logic                                   clk = 1'b0;
    logic                                   reset;
    logic [datapathPkg::dataWidth-1:0]      dataIn;
    logic [datapathPkg::regFunWidth-1:0]    rfFun;
    logic [datapathPkg::groupWidth-1:0]     rfRegSel;
    logic [datapathPkg::groupWidth-1:0]     rfTempSel;
    logic [datapathPkg::rfSelWidth-1:0]     rfOut1Sel;
    logic [datapathPkg::rfSelWidth-1:0]     rfOut2Sel;
    logic                                   rfSrcSel;
    logic [datapathPkg::regFunWidth-1:0]    arfFun;
    logic [datapathPkg::groupWidth-1:0]     arfRegSel;
    logic [datapathPkg::arfSelWidth-1:0]    arfOutASel;
    logic [datapathPkg::arfSelWidth-1:0]    arfOutBSel;
    logic                                   arfSrcSel;
    logic                                   aluSrcSel;
    logic [datapathPkg::aluFunWidth-1:0]    aluFun;
    logic [datapathPkg::dataWidth-1:0]      aluOut;
    logic [datapathPkg::flagWidth-1:0]      flags;
    logic [datapathPkg::dataWidth-1:0]      address;

    int seed = 32'hfe00;
    int fd;
    int cycleCount = 0;
    int cycleLimit = resetCycles + marginCycles;        // Raised once the count is read

    aluSystem aluSystem_inst (
        .clk        (clk),
        .reset      (reset),
        .dataIn     (dataIn),
        .rfFun      (rfFun),
        .rfRegSel   (rfRegSel),
        .rfTempSel  (rfTempSel),
        .rfOut1Sel  (rfOut1Sel),
        .rfOut2Sel  (rfOut2Sel),
        .rfSrcSel   (rfSrcSel),
        .arfFun     (arfFun),
        .arfRegSel  (arfRegSel),
        .arfOutASel (arfOutASel),
        .arfOutBSel (arfOutBSel),
        .arfSrcSel  (arfSrcSel),
        .aluSrcSel  (aluSrcSel),
        .aluFun     (aluFun),
        .aluOut     (aluOut),
        .flags      (flags),
        .address    (address)
    );

    always #10 clk = ~clk;                              // 20 ns period

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            abortRun($sformatf("Timeout: run still going after %0d cycles", cycleLimit));
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkData(
        input string name,
        input logic [datapathPkg::dataWidth-1:0] expected,
        input logic [datapathPkg::dataWidth-1:0] actual
    );
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch at %0t: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    // Flags shown as ZCNO bits
    task automatic checkFlags(
        input logic [datapathPkg::flagWidth-1:0] expected,
        input logic [datapathPkg::flagWidth-1:0] actual
    );
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch at %0t: flags expected %b, got %b",
                               $time, expected, actual));
        end
    endtask

    // Comment lines start with # and blank lines are skipped
    function automatic bit isDataLine(input string text);
        logic [7:0] c;
        for (int i = 0; i < text.len(); i++) begin
            c = text[i];
            if (c == "#") begin
                return 1'b0;
            end
            if (c != " " && c != "\t" && c != "\n" && c != "\r") begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic nextDataLine(output string text, output bit found);
        string raw;
        bit atEnd;
        found = 1'b0;
        atEnd = 1'b0;
        text = "";
        while (!found && !atEnd) begin
            raw = "";
            if ($fgets(raw, fd) == 0) begin
                atEnd = 1'b1;
            end else if (isDataLine(raw)) begin
                text = raw;
                found = 1'b1;
            end
        end
    endtask

    task automatic idleInputs();
        dataIn = '0;
        rfFun = datapathPkg::regLoad;                   // Load with no enables is a no-op
        rfRegSel = '0;
        rfTempSel = '0;
        rfOut1Sel = '0;
        rfOut2Sel = '0;
        rfSrcSel = 1'b0;
        arfFun = datapathPkg::regLoad;
        arfRegSel = '0;
        arfOutASel = '0;
        arfOutBSel = '0;
        arfSrcSel = 1'b0;
        aluSrcSel = 1'b0;
        aluFun = datapathPkg::aluPassA;
    endtask

    initial begin
        string line;
        bit found;
        int vectorCount;
        int fields;
        logic [datapathPkg::dataWidth-1:0] fileData;
        logic randomData;
        logic checkEnable;
        logic [datapathPkg::dataWidth-1:0] expOut;
        logic [datapathPkg::flagWidth-1:0] expFlags;
        logic [datapathPkg::dataWidth-1:0] expAddress;
        logic [31:0] randomWord;

        reset = 1'b1;
        idleInputs();
        fd = $fopen(testFile, "r");
        if (fd == 0) begin
            abortRun({"Cannot open the test vector file ", testFile});
        end
        nextDataLine(line, found);
        if (!found) begin
            abortRun("The test vector file holds no vector count");
        end
        if ($sscanf(line, "%d", vectorCount) != 1 || vectorCount <= 0) begin
            abortRun("The vector count line is not a positive number");
        end
        cycleLimit = resetCycles + vectorCount + marginCycles;

        repeat (resetCycles) @(posedge clk);
        #1;
        checkData("aluOut", '0, aluOut);               // Everything clear out of reset
        checkFlags('0, flags);
        checkData("address", '0, address);
        #1;
        reset = 1'b0;

        for (int i = 0; i < vectorCount; i++) begin
            nextDataLine(line, found);
            if (!found) begin
                abortRun($sformatf("The test vector file ends after %0d of %0d vectors",
                                   i, vectorCount));
            end
            fields = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                rfFun, rfRegSel, rfTempSel, rfOut1Sel, rfOut2Sel, rfSrcSel,
                arfFun, arfRegSel, arfOutASel, arfOutBSel, arfSrcSel,
                aluSrcSel, aluFun, fileData, randomData, checkEnable,
                expOut, expFlags, expAddress);
            if (fields != fieldCount) begin
                abortRun($sformatf("Vector %0d has %0d fields instead of %0d",
                                   i + 1, fields, fieldCount));
            end
            if (randomData) begin
                randomWord = $random(seed);             // dataIn unused on this line
                dataIn = randomWord[datapathPkg::dataWidth-1:0];
            end else begin
                dataIn = fileData;
            end

            @(posedge clk);
            #1;
            if (checkEnable) begin
                checkData("aluOut", expOut, aluOut);
                checkFlags(expFlags, flags);
                checkData("address", expAddress, address);
            end
            #1;
        end

        $fclose(fd);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/aluSystemTests.txt
# rfFun rfRegSel rfTempSel rfOut1Sel rfOut2Sel rfSrcSel arfFun arfRegSel arfOutASel arfOutBSel
# arfSrcSel aluSrcSel aluFun dataIn randomData check expAluOut expFlags(ZCNO) expAddress, hex
61
1 8 0 0 0 1 1 0 0 0 1 0 0 11 0 1 00 8 00
1 4 0 0 0 1 1 0 0 0 1 0 0 22 0 1 00 8 00
1 2 0 0 0 1 1 0 0 0 1 0 0 33 0 1 00 8 00
1 1 0 0 0 1 1 0 0 0 1 0 0 44 0 1 00 8 00
1 0 8 0 0 1 1 0 0 0 1 0 0 55 0 1 00 8 00
1 0 4 0 0 1 1 0 0 0 1 0 0 66 0 1 55 0 00
1 0 2 0 0 1 1 0 0 0 1 0 0 77 0 1 55 0 00
1 0 1 0 0 1 1 0 0 0 1 0 0 80 0 1 55 0 00
1 0 0 4 0 1 1 0 0 0 1 0 0 00 1 1 11 0 00
1 0 0 0 5 1 1 0 0 0 1 0 1 00 1 1 22 0 00
1 0 0 6 0 1 1 0 0 0 1 0 0 00 1 1 33 0 00
1 0 0 0 7 1 1 0 0 0 1 0 1 00 1 1 44 0 00
1 0 0 1 0 1 1 0 0 0 1 0 0 00 1 1 66 0 00
1 0 0 0 2 1 1 0 0 0 1 0 1 00 1 1 77 0 00
1 0 0 3 0 1 1 0 0 0 1 0 0 00 1 1 80 2 00
1 0 0 0 0 1 1 0 0 0 1 0 1 00 1 1 55 0 00
1 0 0 0 0 1 1 4 0 0 1 0 0 3C 0 1 55 0 3C
1 0 0 0 0 1 1 8 0 3 1 0 0 A0 0 1 55 0 A0
1 0 0 0 0 1 1 2 0 1 1 0 0 01 0 1 55 0 01
1 0 0 0 0 1 1 1 0 2 1 0 0 7F 0 1 55 0 7F
1 0 0 0 0 1 3 8 0 3 1 0 0 00 1 1 55 0 A1
1 0 0 0 0 1 2 2 0 1 1 0 0 00 1 1 55 0 00
1 0 0 0 0 1 2 2 0 1 1 0 0 00 1 1 55 0 FF
1 0 0 0 0 1 3 2 0 1 1 0 0 00 1 1 55 0 00
1 0 0 0 0 1 3 5 0 0 1 0 0 00 1 1 55 0 3D
1 0 0 0 0 1 1 0 0 2 1 0 0 00 1 1 55 0 80
1 0 0 0 0 1 0 4 0 0 1 0 0 00 1 1 55 0 00
1 0 0 0 0 1 1 0 3 3 1 1 0 00 1 1 A1 2 A1
1 8 0 0 0 1 1 0 0 0 1 0 0 7F 0 1 55 0 00
1 4 0 0 0 1 1 0 0 0 1 0 0 01 0 1 55 0 00
1 0 0 4 5 1 1 0 0 0 1 0 4 00 1 1 80 3 00
1 8 0 0 0 1 1 0 0 0 1 0 0 FF 0 1 55 1 00
1 0 0 4 5 1 1 0 0 0 1 0 4 00 1 1 00 C 00
1 8 0 0 0 1 1 0 0 0 1 0 0 00 0 1 55 4 00
1 0 0 4 5 1 1 0 0 0 1 0 5 00 1 1 FF 2 00
1 8 0 0 6 1 1 0 0 0 1 0 1 80 0 1 33 0 00
1 0 0 4 5 1 1 0 0 0 1 0 5 00 1 1 7F 5 00
1 0 0 5 5 1 1 0 0 0 1 0 5 00 1 1 00 C 00
1 0 0 0 0 1 1 0 0 0 1 0 2 00 1 1 AA 6 00
1 0 0 0 6 1 1 0 0 0 1 0 3 00 1 1 CC 6 00
1 0 0 1 7 1 1 0 0 0 1 0 7 00 1 1 44 4 00
1 0 0 0 1 1 1 0 0 0 1 0 8 00 1 1 77 4 00
1 0 0 0 0 1 1 0 0 0 1 0 9 00 1 1 AA 6 00
1 0 0 2 2 1 1 0 0 0 1 0 A 00 1 1 00 C 00
1 0 0 1 6 1 1 0 0 0 1 0 6 00 1 1 66 4 00
1 0 0 6 1 1 1 0 0 0 1 0 6 00 1 1 00 C 00
1 0 0 3 0 1 1 0 0 0 1 0 B 00 1 1 00 C 00
1 0 0 0 0 1 1 0 0 0 1 0 B 00 1 1 AA 2 00
1 0 0 2 0 1 1 0 0 0 1 0 C 00 1 1 3B 4 00
1 0 0 3 0 1 1 0 0 0 1 0 F 00 1 1 C0 2 00
1 0 0 3 0 1 1 0 0 0 1 0 F 00 1 1 40 0 00
1 0 0 2 0 1 1 0 0 0 1 0 D 00 1 1 EE 2 00
1 0 0 3 0 1 1 0 0 0 1 0 E 00 1 1 C0 2 00
1 0 0 1 0 1 1 0 0 0 1 0 E 00 1 1 33 0 00
1 0 0 5 0 1 1 0 0 0 1 0 C 00 1 1 00 C 00
1 0 0 0 0 1 1 0 0 0 1 0 F 00 1 1 AA 6 00
1 1 0 7 0 0 1 4 0 0 0 0 0 00 1 1 44 4 AA
1 0 0 0 7 1 3 4 0 0 1 0 1 00 1 1 AA 6 AB
1 0 4 0 0 0 1 0 0 0 1 1 0 00 1 1 AB 6 AB
1 0 0 1 7 1 1 0 0 3 1 0 4 00 1 1 54 5 A1
1 0 0 0 0 1 1 0 0 2 1 0 0 00 1 1 55 5 80

//--- filelist.f
src/datapathPkg.sv
src/registerFile.sv
src/addressRegisterFile.sv
src/aluCore.sv
src/aluSystem.sv
bench/aluSystemTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile=sim.log
topModule=aluSystemTb

verilator --binary --timing -f filelist.f --top-module "$topModule" --Mdir "$buildDir"
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

"./$buildDir/V$topModule" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
fi

if grep -q "^sim passed$" "$logFile"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

//--- src/addressRegisterFile.sv
`timescale 1ns/100ps
`default_nettype none

module addressRegisterFile (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [datapathPkg::dataWidth-1:0]      writeData,
    input  logic [datapathPkg::regFunWidth-1:0]    fun,
    input  logic [datapathPkg::groupWidth-1:0]     regSel,
    input  logic [datapathPkg::arfSelWidth-1:0]    outASel,
    input  logic [datapathPkg::arfSelWidth-1:0]    outBSel,
    output logic [datapathPkg::dataWidth-1:0]      outA,
    output logic [datapathPkg::dataWidth-1:0]      outB
);

    // Stored in read order AR, SP, past-PC, PC
    logic [datapathPkg::dataWidth-1:0] regs [datapathPkg::arfDepth];
    logic [datapathPkg::arfDepth-1:0]  writeEn;

    // Enable group runs PC, AR, SP, past-PC from bit 3 down
    // and is reordered to match the read order
    assign writeEn = {regSel[3], regSel[0], regSel[1], regSel[2]};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < datapathPkg::arfDepth; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < datapathPkg::arfDepth; i++) begin
                if (writeEn[i]) begin
                    regs[i] <= datapathPkg::regNext(fun, regs[i], writeData);
                end
            end
        end
    end

    assign outA = regs[outASel];        // Feeds the ALU A mux
    assign outB = regs[outBSel];        // Address output

endmodule

`default_nettype wire

//--- src/aluCore.sv
`timescale 1ns/100ps
`default_nettype none

module aluCore (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [datapathPkg::dataWidth-1:0]      a,
    input  logic [datapathPkg::dataWidth-1:0]      b,
    input  logic [datapathPkg::aluFunWidth-1:0]    fun,
    output logic [datapathPkg::dataWidth-1:0]      result,
    output logic [datapathPkg::flagWidth-1:0]      flags
);

    logic [datapathPkg::dataWidth-1:0] nextResult;
    logic [datapathPkg::dataWidth:0]   sum;             // Extra bit is the carry out
    logic                              nextCarry;
    logic                              nextOverflow;
    logic                              oldCarry;

    assign oldCarry = flags[datapathPkg::flagC];

    always_comb begin
        nextResult = a;
        sum = '0;
        nextCarry = oldCarry;                           // C and O hold by default
        nextOverflow = flags[datapathPkg::flagO];

        case (fun)
            datapathPkg::aluPassA: nextResult = a;
            datapathPkg::aluPassB: nextResult = b;
            datapathPkg::aluNotA:  nextResult = ~a;
            datapathPkg::aluNotB:  nextResult = ~b;
            datapathPkg::aluAdd: begin
                sum = {1'b0, a} + {1'b0, b};
                nextResult = sum[datapathPkg::dataMsb:0];
                nextCarry = sum[datapathPkg::dataWidth];
                nextOverflow = (a[datapathPkg::dataMsb] == b[datapathPkg::dataMsb]) &&
                               (nextResult[datapathPkg::dataMsb] != a[datapathPkg::dataMsb]);
            end
            datapathPkg::aluSub: begin
                // A + ~B + 1 where a set carry means no borrow
                sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
                nextResult = sum[datapathPkg::dataMsb:0];
                nextCarry = sum[datapathPkg::dataWidth];
                nextOverflow = (a[datapathPkg::dataMsb] != b[datapathPkg::dataMsb]) &&
                               (nextResult[datapathPkg::dataMsb] != a[datapathPkg::dataMsb]);
            end
            datapathPkg::aluMaxA:  nextResult = (a > b) ? a : '0;   // Unsigned compare
            datapathPkg::aluAnd:   nextResult = a & b;
            datapathPkg::aluOr:    nextResult = a | b;
            datapathPkg::aluNand:  nextResult = ~(a & b);
            datapathPkg::aluXor:   nextResult = a ^ b;
            datapathPkg::aluLsl: begin
                nextResult = {a[datapathPkg::dataMsb-1:0], 1'b0};
                nextCarry = a[datapathPkg::dataMsb];
            end
            datapathPkg::aluLsr: begin
                nextResult = {1'b0, a[datapathPkg::dataMsb:1]};
                nextCarry = a[0];
            end
            datapathPkg::aluAsl:   nextResult = {a[datapathPkg::dataMsb-1:0], 1'b0};
            datapathPkg::aluAsr:   nextResult = {a[datapathPkg::dataMsb], a[datapathPkg::dataMsb:1]};
            datapathPkg::aluCsr: begin
                // Rotate right through the stored carry
                nextResult = {oldCarry, a[datapathPkg::dataMsb:1]};
                nextCarry = a[0];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags <= '0;
        end else begin
            result <= nextResult;
            flags[datapathPkg::flagZ] <= (nextResult == '0);
            flags[datapathPkg::flagC] <= nextCarry;
            flags[datapathPkg::flagN] <= nextResult[datapathPkg::dataMsb];
            flags[datapathPkg::flagO] <= nextOverflow;
        end
    end

endmodule

`default_nettype wire

//--- src/aluSystem.sv
`timescale 1ns/100ps
`default_nettype none

module aluSystem (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [datapathPkg::dataWidth-1:0]      dataIn,

    // General register file controls
    input  logic [datapathPkg::regFunWidth-1:0]    rfFun,
    input  logic [datapathPkg::groupWidth-1:0]     rfRegSel,
    input  logic [datapathPkg::groupWidth-1:0]     rfTempSel,
    input  logic [datapathPkg::rfSelWidth-1:0]     rfOut1Sel,
    input  logic [datapathPkg::rfSelWidth-1:0]     rfOut2Sel,
    input  logic                                   rfSrcSel,

    // Address register file controls
    input  logic [datapathPkg::regFunWidth-1:0]    arfFun,
    input  logic [datapathPkg::groupWidth-1:0]     arfRegSel,
    input  logic [datapathPkg::arfSelWidth-1:0]    arfOutASel,
    input  logic [datapathPkg::arfSelWidth-1:0]    arfOutBSel,
    input  logic                                   arfSrcSel,

    input  logic                                   aluSrcSel,
    input  logic [datapathPkg::aluFunWidth-1:0]    aluFun,

    output logic [datapathPkg::dataWidth-1:0]      aluOut,
    output logic [datapathPkg::flagWidth-1:0]      flags,
    output logic [datapathPkg::dataWidth-1:0]      address
);

    logic [datapathPkg::dataWidth-1:0] rfWriteData;
    logic [datapathPkg::dataWidth-1:0] arfWriteData;
    logic [datapathPkg::dataWidth-1:0] rfOut1;
    logic [datapathPkg::dataWidth-1:0] rfOut2;
    logic [datapathPkg::dataWidth-1:0] arfOutA;
    logic [datapathPkg::dataWidth-1:0] aluA;

    // Source mux select 0 picks the ALU result fed back
    assign rfWriteData = rfSrcSel ? dataIn : aluOut;
    assign arfWriteData = arfSrcSel ? dataIn : aluOut;
    assign aluA = aluSrcSel ? arfOutA : rfOut1;     // A operand from either file

    registerFile registerFile_inst (
        .clk       (clk),
        .reset     (reset),
        .writeData (rfWriteData),
        .fun       (rfFun),
        .regSel    (rfRegSel),
        .tempSel   (rfTempSel),
        .out1Sel   (rfOut1Sel),
        .out2Sel   (rfOut2Sel),
        .out1      (rfOut1),
        .out2      (rfOut2)
    );

    addressRegisterFile addressRegisterFile_inst (
        .clk       (clk),
        .reset     (reset),
        .writeData (arfWriteData),
        .fun       (arfFun),
        .regSel    (arfRegSel),
        .outASel   (arfOutASel),
        .outBSel   (arfOutBSel),
        .outA      (arfOutA),
        .outB      (address)
    );

    aluCore aluCore_inst (
        .clk    (clk),
        .reset  (reset),
        .a      (aluA),
        .b      (rfOut2),            // B is always general port 2
        .fun    (aluFun),
        .result (aluOut),
        .flags  (flags)
    );

endmodule

`default_nettype wire

//--- src/datapathPkg.sv
`default_nettype none

package datapathPkg;

    localparam int dataWidth = 8;
    localparam int dataMsb = dataWidth - 1;        // Sign bit of a data word

    // Flag vector layout
    localparam int flagWidth = 4;
    localparam int flagZ = 3;
    localparam int flagC = 2;
    localparam int flagN = 1;
    localparam int flagO = 0;

    // Register group function used by both register files
    localparam int regFunWidth = 2;
    localparam logic [regFunWidth-1:0] regClear = 2'd0;
    localparam logic [regFunWidth-1:0] regLoad = 2'd1;
    localparam logic [regFunWidth-1:0] regDec = 2'd2;
    localparam logic [regFunWidth-1:0] regInc = 2'd3;

    localparam int aluFunWidth = 4;
    localparam logic [aluFunWidth-1:0] aluPassA = 4'd0;
    localparam logic [aluFunWidth-1:0] aluPassB = 4'd1;
    localparam logic [aluFunWidth-1:0] aluNotA = 4'd2;
    localparam logic [aluFunWidth-1:0] aluNotB = 4'd3;
    localparam logic [aluFunWidth-1:0] aluAdd = 4'd4;
    localparam logic [aluFunWidth-1:0] aluSub = 4'd5;
    localparam logic [aluFunWidth-1:0] aluMaxA = 4'd6;
    localparam logic [aluFunWidth-1:0] aluAnd = 4'd7;
    localparam logic [aluFunWidth-1:0] aluOr = 4'd8;
    localparam logic [aluFunWidth-1:0] aluNand = 4'd9;
    localparam logic [aluFunWidth-1:0] aluXor = 4'd10;
    localparam logic [aluFunWidth-1:0] aluLsl = 4'd11;
    localparam logic [aluFunWidth-1:0] aluLsr = 4'd12;
    localparam logic [aluFunWidth-1:0] aluAsl = 4'd13;
    localparam logic [aluFunWidth-1:0] aluAsr = 4'd14;
    localparam logic [aluFunWidth-1:0] aluCsr = 4'd15;

    localparam int rfSelWidth = 3;                  // T1..T4 then R1..R4
    localparam int arfSelWidth = 2;                 // AR, SP, past-PC, PC
    localparam int groupWidth = 4;
    localparam int rfDepth = 2 * groupWidth;
    localparam int arfDepth = groupWidth;

    // Next value of one register under the group function
    function automatic logic [dataWidth-1:0] regNext(
        input logic [regFunWidth-1:0] fun,
        input logic [dataWidth-1:0] current,
        input logic [dataWidth-1:0] writeData
    );
        case (fun)
            regClear: return '0;
            regLoad:  return writeData;
            regDec:   return current - 1'b1;
            default:  return current + 1'b1;    // regInc
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [datapathPkg::dataWidth-1:0]      writeData,
    input  logic [datapathPkg::regFunWidth-1:0]    fun,
    input  logic [datapathPkg::groupWidth-1:0]     regSel,
    input  logic [datapathPkg::groupWidth-1:0]     tempSel,
    input  logic [datapathPkg::rfSelWidth-1:0]     out1Sel,
    input  logic [datapathPkg::rfSelWidth-1:0]     out2Sel,
    output logic [datapathPkg::dataWidth-1:0]      out1,
    output logic [datapathPkg::dataWidth-1:0]      out2
);

    // Storage in read-select order with T1..T4 at 0..3 and R1..R4 at 4..7
    logic [datapathPkg::dataWidth-1:0] regs [datapathPkg::rfDepth];
    logic [datapathPkg::rfDepth-1:0]   writeEn;     // Indexed like regs

    // Group enables run MSB first (bit 3 is R1 or T1)
    always_comb begin
        for (int i = 0; i < datapathPkg::groupWidth; i++) begin
            writeEn[i] = tempSel[datapathPkg::groupWidth-1-i];
            writeEn[datapathPkg::groupWidth+i] = regSel[datapathPkg::groupWidth-1-i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < datapathPkg::rfDepth; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < datapathPkg::rfDepth; i++) begin
                if (writeEn[i]) begin
                    regs[i] <= datapathPkg::regNext(fun, regs[i], writeData);
                end
            end
        end
    end

    // Two independent combinational read ports
    assign out1 = regs[out1Sel];
    assign out2 = regs[out2Sel];

endmodule

`default_nettype wire
